// File: riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] word_t;        // Data and address word
    typedef logic [31:0] instr_t;       // Raw instruction word
    typedef logic [4:0]  reg_idx_t;     // Architectural register index
    typedef logic [2:0]  funct3_t;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // Register-register and register-immediate ALU groups
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

endpackage

`default_nettype wire

// File: core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // Encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_PLUS4,
        WB_IMM
    } wb_src_e;

    typedef struct packed {
        logic                     reg_write;
        wb_src_e                  wb_src;
        alu_op_e                  alu_op;
        logic                     alu_src_imm;   // Operand B from immediate
        logic                     alu_a_pc;      // Operand A from PC
        logic                     mem_write;
        logic                     mem_read;
        mem_size_e                mem_size;
        logic                     mem_unsigned;  // Zero-extend loaded value
        logic                     branch;
        riscv_isa_pkg::funct3_t   branch_funct3;
        logic                     jump;          // JAL or JALR
        logic                     jalr;
        riscv_isa_pkg::reg_idx_t  rs1;
        riscv_isa_pkg::reg_idx_t  rs2;
        riscv_isa_pkg::reg_idx_t  rd;
        logic                     illegal;
    } ctrl_t;

    typedef struct packed {
        logic                     valid;
        riscv_isa_pkg::reg_idx_t  rd;
        riscv_isa_pkg::word_t     value;
        riscv_isa_pkg::word_t     pc;
    } commit_t;

endpackage

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  riscv_isa_pkg::instr_t  instr_i,
    output core_ctrl_pkg::ctrl_t   ctrl_o,
    output riscv_isa_pkg::word_t   imm_o
);

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    opcode_e opcode;
    funct3_t funct3;

    function automatic alu_op_e alu_op_for(input funct3_t f3, input logic alt);
        alu_op_e op;
        op = ALU_ADD;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    always_comb begin
        ctrl_o               = '0;                  // All enables off
        ctrl_o.rs1           = instr_i[19:15];
        ctrl_o.rs2           = instr_i[24:20];
        ctrl_o.rd            = instr_i[11:7];
        ctrl_o.branch_funct3 = funct3;
        ctrl_o.alu_op        = ALU_ADD;
        ctrl_o.wb_src        = WB_ALU;
        ctrl_o.mem_size      = mem_size_e'(funct3[1:0]);
        ctrl_o.mem_unsigned  = funct3[2];
        imm_o                = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type
        case (opcode)
            OPC_LUI: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_src    = WB_IMM;
                imm_o            = {instr_i[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_a_pc    = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                imm_o              = {instr_i[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_src    = WB_PC_PLUS4;
                ctrl_o.jump      = 1'b1;
                imm_o            = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                    instr_i[20], instr_i[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.wb_src      = WB_PC_PLUS4;
                ctrl_o.jump        = 1'b1;
                ctrl_o.jalr        = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;                // Target is rs1 + imm
            end
            OPC_BRANCH: begin
                ctrl_o.branch = 1'b1;
                imm_o         = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                 instr_i[30:25], instr_i[11:8], 1'b0};
            end
            OPC_LOAD: begin
                if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    ctrl_o.reg_write   = 1'b1;
                    ctrl_o.wb_src      = WB_MEM;
                    ctrl_o.mem_read    = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end else begin
                    ctrl_o.illegal = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                    ctrl_o.mem_write   = 1'b1;
                    ctrl_o.alu_src_imm = 1'b1;
                end else begin
                    ctrl_o.illegal = 1'b1;
                end
                imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            OPC_OP_IMM: begin
                ctrl_o.reg_write   = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = alu_op_for(funct3, instr_i[30] && funct3 == F3_SRL_SRA);
            end
            OPC_OP: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.alu_op    = alu_op_for(funct3, instr_i[30]);
            end
            default: ctrl_o.illegal = 1'b1;           // Executes as a no-op
        endcase
    end

    // An illegal word must never reach the register file or data memory
    always_comb begin
        illegal_no_write: assert #0 (!(ctrl_o.illegal && (ctrl_o.reg_write || ctrl_o.mem_write)))
            else $error("illegal instruction decoded with a write enable");
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  riscv_isa_pkg::reg_idx_t  rs1_i,
    input  riscv_isa_pkg::reg_idx_t  rs2_i,
    input  riscv_isa_pkg::reg_idx_t  rd_i,
    input  logic                     write_i,
    input  riscv_isa_pkg::word_t     write_data_i,
    output riscv_isa_pkg::word_t     rs1_data_o,
    output riscv_isa_pkg::word_t     rs2_data_o
);

    import riscv_isa_pkg::*;

    word_t regs [1:31];                               // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_i && rd_i != '0) begin
            regs[rd_i] <= write_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  core_ctrl_pkg::ctrl_t    ctrl_i,
    input  riscv_isa_pkg::word_t    imm_i,
    input  riscv_isa_pkg::word_t    pc_i,
    input  riscv_isa_pkg::word_t    wb_value_i,
    output riscv_isa_pkg::word_t    alu_result_o,
    output riscv_isa_pkg::word_t    rs2_value_o,
    output logic                    branch_taken_o,
    output core_ctrl_pkg::commit_t  commit_o
);

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    word_t rs1_value;
    word_t op_a;
    word_t op_b;
    logic  taken;

    reg_file regs (

        .clk_i        ( clk_i ),
        .reset_i      ( reset_i ),
        .rs1_i        ( ctrl_i.rs1 ),
        .rs2_i        ( ctrl_i.rs2 ),
        .rd_i         ( ctrl_i.rd ),
        .write_i      ( ctrl_i.reg_write ),
        .write_data_i ( wb_value_i ),

        .rs1_data_o   ( rs1_value ),
        .rs2_data_o   ( rs2_value_o )

    );

    assign op_a = ctrl_i.alu_a_pc    ? pc_i  : rs1_value;   // AUIPC uses the PC
    assign op_b = ctrl_i.alu_src_imm ? imm_i : rs2_value_o;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:  alu_result_o = op_a + op_b;
            ALU_SUB:  alu_result_o = op_a - op_b;
            ALU_SLL:  alu_result_o = op_a << op_b[4:0];
            ALU_SLT:  alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result_o = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result_o = op_a ^ op_b;
            ALU_SRL:  alu_result_o = op_a >> op_b[4:0];
            ALU_SRA:  alu_result_o = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_result_o = op_a | op_b;
            ALU_AND:  alu_result_o = op_a & op_b;
            default:  alu_result_o = '0;
        endcase
    end

    // Branches compare the two registers directly, not the ALU output
    always_comb begin
        case (ctrl_i.branch_funct3)
            F3_BEQ:  taken = rs1_value == rs2_value_o;
            F3_BNE:  taken = rs1_value != rs2_value_o;
            F3_BLT:  taken = $signed(rs1_value) < $signed(rs2_value_o);
            F3_BGE:  taken = $signed(rs1_value) >= $signed(rs2_value_o);
            F3_BLTU: taken = rs1_value < rs2_value_o;
            F3_BGEU: taken = rs1_value >= rs2_value_o;
            default: taken = 1'b0;
        endcase
    end

    assign branch_taken_o = ctrl_i.branch && taken;

    always_comb begin
        commit_o.valid = ctrl_i.reg_write && ctrl_i.rd != '0 && !reset_i;  // x0 never reported
        commit_o.rd    = ctrl_i.rd;
        commit_o.value = wb_value_i;
        commit_o.pc    = pc_i;
    end

endmodule

`default_nettype wire

// File: mem_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module mem_writeback #(

    parameter int unsigned DMEM_ADDR_BITS = 10

) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  core_ctrl_pkg::ctrl_t  ctrl_i,
    input  riscv_isa_pkg::word_t  alu_result_i,
    input  riscv_isa_pkg::word_t  rs2_value_i,
    input  riscv_isa_pkg::word_t  imm_i,
    input  riscv_isa_pkg::word_t  pc_plus4_i,
    output riscv_isa_pkg::word_t  wb_value_o
);

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    typedef logic [DMEM_ADDR_BITS-1:0] dmem_addr_t;

    logic [7:0] mem [0:(2**DMEM_ADDR_BITS)-1];

    dmem_addr_t addr;
    dmem_addr_t base;                                 // Word-aligned base of the access
    logic [1:0] offset;
    logic [3:0] byte_en;
    word_t      store_data;
    word_t      load_word;
    word_t      load_shifted;
    word_t      load_value;

    assign addr   = alu_result_i[DMEM_ADDR_BITS-1:0];
    assign offset = addr[1:0];
    assign base   = {addr[DMEM_ADDR_BITS-1:2], 2'b00};

    always_comb begin
        case (ctrl_i.mem_size)
            MEM_BYTE: byte_en = 4'b0001 << offset;
            MEM_HALF: byte_en = 4'b0011 << offset;
            default:  byte_en = 4'b1111;
        endcase
        store_data = rs2_value_i << {offset, 3'b000};  // Move data onto its lanes
    end

    always_ff @(posedge clk_i) begin
        if (!reset_i && ctrl_i.mem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[base + dmem_addr_t'(i)] <= store_data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            load_word[8*i +: 8] = mem[base + dmem_addr_t'(i)];
        end
        load_shifted = load_word >> {offset, 3'b000};
        case (ctrl_i.mem_size)
            MEM_BYTE: load_value = ctrl_i.mem_unsigned ? {24'b0, load_shifted[7:0]}
                                                       : {{24{load_shifted[7]}}, load_shifted[7:0]};
            MEM_HALF: load_value = ctrl_i.mem_unsigned ? {16'b0, load_shifted[15:0]}
                                                       : {{16{load_shifted[15]}}, load_shifted[15:0]};
            default:  load_value = load_word;
        endcase
    end

    always_comb begin
        case (ctrl_i.wb_src)
            WB_MEM:      wb_value_o = load_value;
            WB_PC_PLUS4: wb_value_o = pc_plus4_i;     // Link address of JAL and JALR
            WB_IMM:      wb_value_o = imm_i;
            default:     wb_value_o = alu_result_i;
        endcase
    end

    access_in_range_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        (ctrl_i.mem_read || ctrl_i.mem_write) |->
            ((alu_result_i >> DMEM_ADDR_BITS) == '0) &&
            (ctrl_i.mem_size != MEM_HALF || offset[0] == 1'b0) &&
            (ctrl_i.mem_size != MEM_WORD || offset == 2'b00))
        else $error("data access out of range or misaligned at %h", alu_result_i);

endmodule

`default_nettype wire

// File: pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(

    parameter riscv_isa_pkg::word_t RESET_PC = '0

) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  core_ctrl_pkg::ctrl_t  ctrl_i,
    input  riscv_isa_pkg::word_t  imm_i,
    input  riscv_isa_pkg::word_t  alu_result_i,
    input  logic                  branch_taken_i,
    output riscv_isa_pkg::word_t  pc_o,
    output riscv_isa_pkg::word_t  pc_plus4_o
);

    import riscv_isa_pkg::*;

    word_t next_pc;

    assign pc_plus4_o = pc_o + 32'd4;

    always_comb begin
        if (ctrl_i.jalr) begin
            next_pc = {alu_result_i[31:1], 1'b0};     // rs1 + imm, bit 0 dropped
        end else if (ctrl_i.jump || branch_taken_i) begin
            next_pc = pc_o + imm_i;
        end else begin
            next_pc = pc_plus4_o;                     // Also the path for illegal words
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= next_pc;
        end
    end

    pc_word_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        pc_o[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_o);

endmodule

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(

    parameter int unsigned          DMEM_ADDR_BITS = 10,  // Data memory is 2**N bytes
    parameter riscv_isa_pkg::word_t RESET_PC       = '0

) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  riscv_isa_pkg::instr_t   instr_i,
    output riscv_isa_pkg::word_t    instr_addr_o,
    output core_ctrl_pkg::commit_t  commit_o
);

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    ctrl_t ctrl;                                      // Decoded control of this cycle
    word_t imm;
    word_t pc;
    word_t pc_plus4;
    word_t alu_result;
    word_t rs2_value;
    word_t wb_value;
    logic  branch_taken;

    assign instr_addr_o = pc;                         // Fetch address back to instruction memory

    instr_decoder decoder (

        .instr_i ( instr_i ),

        .ctrl_o  ( ctrl ),
        .imm_o   ( imm )

    );

    pc_unit #( .RESET_PC( RESET_PC ) ) pc_ctrl (

        .clk_i          ( clk_i ),
        .reset_i        ( reset_i ),
        .ctrl_i         ( ctrl ),
        .imm_i          ( imm ),
        .alu_result_i   ( alu_result ),
        .branch_taken_i ( branch_taken ),

        .pc_o           ( pc ),
        .pc_plus4_o     ( pc_plus4 )

    );

    alu_exec execute (

        .clk_i          ( clk_i ),
        .reset_i        ( reset_i ),
        .ctrl_i         ( ctrl ),
        .imm_i          ( imm ),
        .pc_i           ( pc ),
        .wb_value_i     ( wb_value ),

        .alu_result_o   ( alu_result ),
        .rs2_value_o    ( rs2_value ),
        .branch_taken_o ( branch_taken ),
        .commit_o       ( commit_o )

    );

    mem_writeback #( .DMEM_ADDR_BITS( DMEM_ADDR_BITS ) ) result (

        .clk_i        ( clk_i ),
        .reset_i      ( reset_i ),
        .ctrl_i       ( ctrl ),
        .alu_result_i ( alu_result ),
        .rs2_value_i  ( rs2_value ),
        .imm_i        ( imm ),
        .pc_plus4_i   ( pc_plus4 ),

        .wb_value_o   ( wb_value )

    );

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    import riscv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int unsigned DMEM_ADDR_BITS = 10;
    localparam word_t       RESET_PC       = 32'h0000_0000;
    localparam int          PROG_LEN       = 200;
    localparam int          RESET_CYCLES   = 8;
    localparam int          CYCLE_LIMIT    = 4 * PROG_LEN + RESET_CYCLES;
    localparam instr_t      SELF_JUMP      = 32'h0000_006f;  // jal x0, 0
    localparam instr_t      ILLEGAL_WORD   = 32'hffff_ffff;  // Opcode 7'h7f is not decoded
    localparam instr_t      NOP            = 32'h0000_0013;

    typedef logic [DMEM_ADDR_BITS-1:0] daddr_t;

    logic    clk_i;
    logic    reset_i;
    instr_t  instr_i;
    word_t   instr_addr_o;
    commit_t commit_o;

    instr_t      imem [0:255];
    word_t       model_regs [0:31];
    logic [7:0]  model_mem [0:(2**DMEM_ADDR_BITS)-1];
    word_t       model_pc;
    word_t       next_pc;
    instr_t      fetched;
    commit_t     expected;
    logic [31:0] lfsr_state;
    logic        running;
    int          cycles;
    int          steps;

    rv_core_top #(
        .DMEM_ADDR_BITS ( DMEM_ADDR_BITS ),
        .RESET_PC       ( RESET_PC )
    ) uut (
        .clk_i        ( clk_i ),
        .reset_i      ( reset_i ),
        .instr_i      ( instr_i ),
        .instr_addr_o ( instr_addr_o ),
        .commit_o     ( commit_o )
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_commit(input string name, input commit_t exp, input commit_t act);
        if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
            stop_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_pc(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            stop_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic reg_idx_t pick_reg();
        logic [31:0] r;
        r = rand_bits(3);                               // Only x0 to x7
        return {2'b00, r[2:0]};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input funct3_t f3, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3,
                                     input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // One body instruction at word index pos; control flow only jumps forward
    function automatic instr_t random_instr(input logic [7:0] pos);
        logic [31:0] kind;
        logic [31:0] r;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        funct3_t     f3;
        logic [11:0] addr;
        logic [12:0] hop;
        word_t       target;
        instr_t      ins;
        kind = rand_bits(4);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        ins  = NOP;
        case (kind[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                r  = rand_bits(3);
                f3 = r[2:0];
                r  = rand_bits(12);
                if (f3 == F3_SLL) begin
                    r[11:5] = 7'b0;
                end else if (f3 == F3_SRL_SRA) begin
                    r[11:5] = {1'b0, r[10], 5'b0};      // SRLI or SRAI
                end
                ins = enc_i(r[11:0], rs1, f3, rd, OPC_OP_IMM);
            end
            4'd4, 4'd5, 4'd6: begin
                r  = rand_bits(4);
                f3 = r[2:0];
                ins = enc_r({1'b0, r[3] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA), 5'b0},
                            rs2, rs1, f3, rd);
            end
            4'd7: begin
                r   = rand_bits(21);
                ins = enc_u(r[19:0], rd, r[20] ? OPC_AUIPC : OPC_LUI);
            end
            4'd8, 4'd9: begin
                r = rand_bits(3);
                case (r[2:0])
                    3'd0, 3'd7: f3 = F3_LB;
                    3'd1, 3'd6: f3 = F3_LH;
                    3'd2, 3'd5: f3 = F3_LW;
                    3'd3:       f3 = F3_LBU;
                    default:    f3 = F3_LHU;
                endcase
                r    = rand_bits(6);
                addr = {6'b0, r[5:0]};
                if (f3[1:0] == 2'd1) addr[0] = 1'b0;
                if (f3[1:0] == 2'd2) addr[1:0] = 2'b00;
                ins = enc_i(addr, 5'd0, f3, rd, OPC_LOAD);
            end
            4'd10, 4'd11: begin
                r  = rand_bits(8);
                f3 = (r[1:0] == 2'd3) ? F3_SW : {1'b0, r[1:0]};
                addr = {6'b0, r[7:2]};
                if (f3 == F3_SH) addr[0] = 1'b0;
                if (f3 == F3_SW) addr[1:0] = 2'b00;
                ins = enc_s(addr, rs2, 5'd0, f3);
            end
            4'd12, 4'd13: begin
                r   = rand_bits(3);
                hop = r[2] ? 13'd12 : 13'd8;
                ins = enc_b(hop, rs2, rs1, {r[1], 1'b0, r[0]});  // BEQ, BNE, BLT, BGE
            end
            4'd14: begin
                r   = rand_bits(1);
                hop = r[0] ? 13'd12 : 13'd8;
                ins = enc_j({8'b0, hop}, rd);
            end
            default: begin
                r      = rand_bits(1);
                target = {22'b0, pos, 2'b00} + (r[0] ? 32'd12 : 32'd8);
                ins    = enc_i(target[11:0], 5'd0, 3'b000, rd, OPC_JALR);
            end
        endcase
        return ins;
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [7:0]  idx;
        logic [4:0]  k;
        imem = '{default: SELF_JUMP};                   // Tail and spare words end the run
        idx  = 8'd0;
        for (k = 5'd1; k < 5'd8; k++) begin
            r = rand_bits(20);
            imem[idx] = enc_u(r[19:0], k, OPC_LUI);
            r = rand_bits(12);
            imem[idx + 8'd1] = enc_i(r[11:0], k, F3_ADD_SUB, k, OPC_OP_IMM);
            idx = idx + 8'd2;
        end
        for (k = 5'd0; k < 5'd16; k++) begin
            imem[idx] = enc_s({5'b0, k, 2'b00}, pick_reg(), 5'd0, F3_SW);  // Fill bytes 0 to 63
            idx = idx + 8'd1;
        end
        imem[idx] = ILLEGAL_WORD;
        idx = idx + 8'd1;
        while (int'(idx) < PROG_LEN - 4) begin
            imem[idx] = random_instr(idx);
            idx = idx + 8'd1;
        end
    endtask

    function automatic word_t alu_ref(input funct3_t f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t y;
        case (f3)
            F3_ADD_SUB: y = alt ? a - b : a + b;
            F3_SLL:     y = a << b[4:0];
            F3_SLT:     y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    y = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     y = a ^ b;
            F3_SRL_SRA: y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            F3_OR:      y = a | b;
            default:    y = a & b;
        endcase
        return y;
    endfunction

    function automatic logic branch_ref(input funct3_t f3, input word_t a, input word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t load_ref(input funct3_t f3, input word_t addr);
        daddr_t     a;
        logic [7:0] b0;
        logic [7:0] b1;
        word_t      w;
        a  = daddr_t'(addr);
        b0 = model_mem[a];
        b1 = model_mem[a + daddr_t'(1)];
        case (f3)
            F3_LB:   w = {{24{b0[7]}}, b0};
            F3_LH:   w = {{16{b1[7]}}, b1, b0};
            F3_LBU:  w = {24'b0, b0};
            F3_LHU:  w = {16'b0, b1, b0};
            default: w = {model_mem[a + daddr_t'(3)], model_mem[a + daddr_t'(2)], b1, b0};
        endcase
        return w;
    endfunction

    function automatic void store_ref(input funct3_t f3, input word_t addr, input word_t data);
        daddr_t a;
        a = daddr_t'(addr);
        model_mem[a] = data[7:0];
        if (f3 != F3_SB) model_mem[a + daddr_t'(1)] = data[15:8];
        if (f3 == F3_SW) begin
            model_mem[a + daddr_t'(2)] = data[23:16];
            model_mem[a + daddr_t'(3)] = data[31:24];
        end
    endfunction

    // Executes one instruction on the model state, returns the expected commit
    function automatic commit_t ref_step(input instr_t ins, input word_t pc,
                                         output word_t npc);
        commit_t  c;
        reg_idx_t rd;
        funct3_t  f3;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    res;
        logic     wr;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        npc   = pc + 32'd4;
        wr    = 1'b1;
        res   = '0;
        case (ins[6:0])
            OPC_LUI:    res = {ins[31:12], 12'b0};
            OPC_AUIPC:  res = pc + {ins[31:12], 12'b0};
            OPC_OP_IMM: res = alu_ref(f3, ins[30] && f3 == F3_SRL_SRA, a, imm_i);
            OPC_OP:     res = alu_ref(f3, ins[30], a, b);
            OPC_LOAD:   res = load_ref(f3, a + imm_i);
            OPC_JAL: begin
                res = pc + 32'd4;
                npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                res = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_ref(f3, a, b)) begin
                    npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_STORE: begin
                wr = 1'b0;
                store_ref(f3, a + {{20{ins[31]}}, ins[31:25], ins[11:7]}, b);
            end
            default: wr = 1'b0;                           // Unknown word retires as no-op
        endcase
        if (wr && rd != 5'd0) model_regs[rd] = res;
        c.valid = wr && rd != 5'd0;
        c.rd    = rd;
        c.value = res;
        c.pc    = pc;
        return c;
    endfunction

    initial begin
        lfsr_state = 32'hb5c0_5b7d;
        running    = 1'b0;
        cycles     = 0;
        steps      = 0;
        reset_i    = 1'b1;
        model_pc   = RESET_PC;
        model_regs = '{default: 32'h0};
        model_mem  = '{default: 8'h00};
        build_program();
        instr_i    = imem[RESET_PC[9:2]];             // LUI to x1, a real write held off by reset
        repeat (RESET_CYCLES) begin
            @(posedge clk_i);
            if (commit_o.valid !== 1'b0) stop_run("commit_o.valid was high during reset");
        end
        @(negedge clk_i);
        reset_i = 1'b0;
        check_pc("fetch address after reset", RESET_PC, instr_addr_o);
        instr_i = imem[instr_addr_o[9:2]];
        running = 1'b1;
        forever begin
            @(negedge clk_i);
            instr_i = imem[instr_addr_o[9:2]];        // Next word after the PC update
        end
    end

    always @(posedge clk_i) begin
        if (running) begin
            check_pc($sformatf("fetch address at step %0d", steps), model_pc, instr_addr_o);
            fetched  = imem[model_pc[9:2]];
            expected = ref_step(fetched, model_pc, next_pc);
            check_commit($sformatf("commit at pc %h", model_pc), expected, commit_o);
            model_pc = next_pc;
            steps++;
            if (fetched == SELF_JUMP) begin
                $display("Final self-jump reached after %0d instructions", steps);
                $display("Result: PASSED");
                $finish;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            stop_run($sformatf("Timeout: no final self-jump within %0d cycles", CYCLE_LIMIT));
        end
    end

endmodule

`default_nettype wire

// File: build.f
riscv_isa_pkg.sv
core_ctrl_pkg.sv
instr_decoder.sv
reg_file.sv
alu_exec.sv
mem_writeback.sv
pc_unit.sv
rv_core_top.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status is the result
cd "$(dirname "$0")" \
    && verilator --binary --timing -f build.f --top-module tb_rv_core -o tb_rv_core_sim \
    && ./obj_dir/tb_rv_core_sim \
    || { echo "Simulation did not pass"; exit 1; }
